// File: hw/exec_consts.svh
/*
 * Width and size constants for the integer execute pipeline.
 * Included by the shared package and by any RTL file that sizes
 * logic directly from these numbers.
 */

`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Data path word width
`define EXEC_XLEN 32

// Register file depth, r0 included
`define EXEC_NREGS 16

// Bits needed to index one register
`define EXEC_REG_IDX_W 4

// Immediate field width in the register-immediate format
`define EXEC_IMM_W 16

`endif

// File: hw/exec_pkg.sv
/*
 * Shared types of the execute pipeline.
 * Holds the data word, register index, opcode and operand-select
 * types, plus both instruction formats overlaid in one packed union.
 * Referenced by scoped names from every stage.
 */

`include "exec_consts.svh"

package exec_pkg;

	typedef logic [`EXEC_XLEN-1:0] word_t;
	typedef logic [`EXEC_REG_IDX_W-1:0] reg_idx_t;

	// ALU opcodes, same encoding in both formats
	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SLT
	} alu_op_e;

	// Operand source, imm only meaningful for operand B
	typedef enum logic [1:0] {
		SEL_RF, SEL_IMM, SEL_EX_FORW, SEL_WB_FORW
	} operand_sel_e;

	// Register-register format, is_imm low
	typedef struct packed {
		alu_op_e       op;
		logic          is_imm;
		reg_idx_t      rd;
		reg_idx_t      ra;
		reg_idx_t      rb;
		logic [15:0]   rsvd;
	} instr_rr_t;

	// Register-immediate format, is_imm high
	typedef struct packed {
		alu_op_e                 op;
		logic                    is_imm;
		reg_idx_t                rd;
		reg_idx_t                ra;
		logic [3:0]              rsvd;
		logic [`EXEC_IMM_W-1:0]  simm;
	} instr_ri_t;

	// One 32-bit word, two views, selected by is_imm
	typedef union packed {
		instr_rr_t rr;
		instr_ri_t ri;
	} instr_u;

endpackage

// File: hw/operand_if.sv
/*
 * Decoded instruction from the issue stage to the operand multiplexer.
 * Carries the register file reads, the extended immediate and the
 * forwarding selects worked out during decode.
 */

`timescale 1ns/10ps

interface operand_if;

	logic                      d_valid;
	exec_pkg::alu_op_e         op;
	exec_pkg::reg_idx_t        rd;

	// Register file data for both sources
	exec_pkg::word_t           rf_a;
	exec_pkg::word_t           rf_b;

	// Sign-extended simm
	exec_pkg::word_t           imm;

	exec_pkg::operand_sel_e    sel_a;
	exec_pkg::operand_sel_e    sel_b;

	modport issue (output d_valid, op, rd, rf_a, rf_b, imm, sel_a, sel_b);
	modport operand (input d_valid, op, rd, rf_a, rf_b, imm, sel_a, sel_b);

endinterface

// File: hw/exec_if.sv
/*
 * Execute-stage register contents, from the operand multiplexer
 * to the ALU. Valid and destination are also tapped at the top level
 * for forwarding and writeback.
 */

`timescale 1ns/10ps

interface exec_if;

	logic                  ex_valid;
	exec_pkg::alu_op_e     ex_op;
	exec_pkg::reg_idx_t    ex_rd;
	exec_pkg::word_t       operand_a;
	exec_pkg::word_t       operand_b;

	modport operand (output ex_valid, ex_op, ex_rd, operand_a, operand_b);

	// ALU only needs the opcode and the operands
	modport alu (input ex_op, operand_a, operand_b);

endinterface

// File: hw/reg_file.sv
/*
 * General purpose register file.
 * Two combinational read ports, one synchronous write port.
 * r0 has no storage and always reads as zero.
 */

`timescale 1ns/10ps

`include "exec_consts.svh"

module reg_file (
	input  logic                clk,
	input  logic                rst_n,
	input  exec_pkg::reg_idx_t  rd_idx_a,
	input  exec_pkg::reg_idx_t  rd_idx_b,
	output exec_pkg::word_t     rd_data_a,
	output exec_pkg::word_t     rd_data_b,
	input  logic                wr_en,
	input  exec_pkg::reg_idx_t  wr_idx,
	input  exec_pkg::word_t     wr_data
);

	// Storage for r1 upward only
	exec_pkg::word_t regs [1:`EXEC_NREGS-1];

	// Write port, writes to r0 dropped
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < `EXEC_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_idx != '0)) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Read ports
	assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
	assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

endmodule

// File: hw/issue_decode.sv
/*
 * Issue and decode stage.
 * Takes instruction words on the valid/ready input into the decode
 * register, splits them by format, reads the register file and picks
 * a forwarding source for each operand. The register file write port
 * is fed from writeback through this stage.
 */

`timescale 1ns/10ps

`include "exec_consts.svh"

module issue_decode (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                instr_valid,
	output logic                instr_ready,
	input  exec_pkg::instr_u    instr_word,
	input  logic                pipe_advance,
	input  logic                ex_valid,
	input  exec_pkg::reg_idx_t  ex_rd,
	input  logic                wb_valid,
	input  exec_pkg::reg_idx_t  wb_rd,
	input  exec_pkg::word_t     wb_data,
	input  exec_pkg::reg_idx_t  rf_wr_idx,
	input  logic                rf_wr_en,
	operand_if.issue            opi
);

	logic              d_valid;
	exec_pkg::instr_u  d_instr;

	// Priority: execute, then writeback, then register file
	function automatic exec_pkg::operand_sel_e fwd_sel(
		input exec_pkg::reg_idx_t src,
		input logic               ex_v,
		input exec_pkg::reg_idx_t ex_idx,
		input logic               wb_v,
		input exec_pkg::reg_idx_t wb_idx
	);
		exec_pkg::operand_sel_e sel;
		sel = exec_pkg::SEL_RF;
		if (src != '0) begin
			if (ex_v && (ex_idx == src)) begin
				sel = exec_pkg::SEL_EX_FORW;
			end else if (wb_v && (wb_idx == src)) begin
				sel = exec_pkg::SEL_WB_FORW;
			end
		end
		return sel;
	endfunction

	////////////////////
	// Decode register
	////////////////////

	// Room in decode when empty or when its content moves on
	assign instr_ready = !d_valid || pipe_advance;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			d_valid <= 1'b0;
			d_instr <= '0;
		end else if (instr_ready) begin
			d_valid <= instr_valid;
			d_instr <= instr_word;
		end
	end

	////////////////////
	// Field decode
	////////////////////

	// op, rd and ra sit at the same place in both views
	assign opi.d_valid = d_valid;
	assign opi.op      = d_instr.rr.op;
	assign opi.rd      = d_instr.rr.rd;
	assign opi.imm     = {{(`EXEC_XLEN-`EXEC_IMM_W){d_instr.ri.simm[`EXEC_IMM_W-1]}},
		d_instr.ri.simm};

	reg_file u_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_idx_a  (d_instr.rr.ra),
		.rd_idx_b  (d_instr.rr.rb),
		.rd_data_a (opi.rf_a),
		.rd_data_b (opi.rf_b),
		.wr_en     (rf_wr_en),
		.wr_idx    (rf_wr_idx),
		.wr_data   (wb_data)
	);

	// Operand selects
	assign opi.sel_a = fwd_sel(d_instr.rr.ra, ex_valid, ex_rd, wb_valid, wb_rd);
	assign opi.sel_b = d_instr.ri.is_imm ? exec_pkg::SEL_IMM :
		fwd_sel(d_instr.rr.rb, ex_valid, ex_rd, wb_valid, wb_rd);

endmodule

// File: hw/operand_mux.sv
/*
 * Operand forwarding and execute-stage register.
 * Operand A comes from the register file or one of the two forwarding
 * paths, operand B may also take the immediate. The chosen values
 * are captured together with op, rd and valid on each pipeline advance.
 */

`timescale 1ns/10ps

module operand_mux (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             pipe_advance,
	input  exec_pkg::word_t  ex_forw,
	input  exec_pkg::word_t  wb_forw,
	operand_if.operand       opi,
	exec_if.operand          exi
);

	exec_pkg::word_t muxed_a;
	exec_pkg::word_t muxed_b;

	////////////////////
	// Forwarding muxes
	////////////////////

	// Operand A, imm never selected here
	always_comb begin
		case (opi.sel_a)
			exec_pkg::SEL_EX_FORW: muxed_a = ex_forw;
			exec_pkg::SEL_WB_FORW: muxed_a = wb_forw;
			default:               muxed_a = opi.rf_a;
		endcase
	end

	// Operand B
	always_comb begin
		case (opi.sel_b)
			exec_pkg::SEL_IMM:     muxed_b = opi.imm;
			exec_pkg::SEL_EX_FORW: muxed_b = ex_forw;
			exec_pkg::SEL_WB_FORW: muxed_b = wb_forw;
			default:               muxed_b = opi.rf_b;
		endcase
	end

	////////////////////
	// Execute register
	////////////////////

	// Whole pipe freezes together, so sources are stable while held
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exi.ex_valid  <= 1'b0;
			exi.ex_op     <= exec_pkg::ALU_ADD;
			exi.ex_rd     <= '0;
			exi.operand_a <= '0;
			exi.operand_b <= '0;
		end else if (pipe_advance) begin
			// Bubble enters when decode is empty
			exi.ex_valid  <= opi.d_valid;
			exi.ex_op     <= opi.op;
			exi.ex_rd     <= opi.rd;
			exi.operand_a <= muxed_a;
			exi.operand_b <= muxed_b;
		end
	end

endmodule

// File: hw/exec_alu.sv
/*
 * Integer ALU on the execute-stage operands.
 * Purely combinational. The result feeds the writeback register
 * and the execute forwarding path.
 */

`timescale 1ns/10ps

module exec_alu (
	exec_if.alu              exi,
	output exec_pkg::word_t  alu_result
);

	logic [4:0] shamt;
	logic       lt_signed;

	// Shift amount from low bits of B
	assign shamt = exi.operand_b[4:0];

	// Signed compare for slt
	assign lt_signed = $signed(exi.operand_a) < $signed(exi.operand_b);

	always_comb begin
		alu_result = '0;
		case (exi.ex_op)
			exec_pkg::ALU_ADD: begin
				alu_result = exi.operand_a + exi.operand_b;
			end
			exec_pkg::ALU_SUB: begin
				alu_result = exi.operand_a - exi.operand_b;
			end
			exec_pkg::ALU_AND: begin
				alu_result = exi.operand_a & exi.operand_b;
			end
			exec_pkg::ALU_OR: begin
				alu_result = exi.operand_a | exi.operand_b;
			end
			exec_pkg::ALU_XOR: begin
				alu_result = exi.operand_a ^ exi.operand_b;
			end
			exec_pkg::ALU_SLL: begin
				alu_result = exi.operand_a << shamt;
			end
			// Logical, zeros shifted in
			exec_pkg::ALU_SRL: begin
				alu_result = exi.operand_a >> shamt;
			end
			// 1 or 0 in bit 0
			exec_pkg::ALU_SLT: begin
				alu_result[0] = lt_signed;
			end
			default: begin
				alu_result = '0;
			end
		endcase
	end

endmodule

// File: hw/writeback_stage.sv
/*
 * Writeback and output stage.
 * Holds the finished result until the consumer takes it, writes the
 * register file on that transfer, and derives the global advance
 * from the output handshake.
 */

`timescale 1ns/10ps

module writeback_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ex_valid,
	input  exec_pkg::reg_idx_t  ex_rd,
	input  exec_pkg::word_t     alu_result,
	output logic                res_valid,
	input  logic                res_ready,
	output exec_pkg::reg_idx_t  res_rd,
	output exec_pkg::word_t     res_data,
	output logic                wb_valid,
	output exec_pkg::reg_idx_t  wb_rd,
	output exec_pkg::word_t     wb_data,
	output logic                rf_wr_en,
	output logic                pipe_advance
);

	// Whole pipeline moves when the result slot frees up
	assign pipe_advance = !wb_valid || res_ready;

	////////////////////
	// Result register
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_rd    <= '0;
			wb_data  <= '0;
		end else if (pipe_advance) begin
			wb_valid <= ex_valid;
			wb_rd    <= ex_rd;
			wb_data  <= alu_result;
		end
	end

	// Output side, held while res_ready is low
	assign res_valid = wb_valid;
	assign res_rd    = wb_rd;
	assign res_data  = wb_data;

	// Commit to the register file at the output transfer
	assign rf_wr_en = wb_valid && res_ready;

endmodule

// File: hw/exec_core_top.sv
/*
 * Top level of the execute pipeline.
 * Plain valid/ready ports for instructions in and results out.
 * Connects decode, operand mux, ALU and writeback.
 */

`timescale 1ns/10ps

module exec_core_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                instr_valid,
	output logic                instr_ready,
	input  exec_pkg::word_t     instr_word,
	output logic                res_valid,
	input  logic                res_ready,
	output exec_pkg::reg_idx_t  res_rd,
	output exec_pkg::word_t     res_data
);

	exec_pkg::word_t     alu_result;
	logic                wb_valid;
	exec_pkg::reg_idx_t  wb_rd;
	exec_pkg::word_t     wb_data;
	logic                rf_wr_en;
	logic                pipe_advance;

	operand_if opi ();
	exec_if    exi ();

	// Input side
	issue_decode u_issue_decode (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.instr_ready  (instr_ready),
		.instr_word   (instr_word),
		.pipe_advance (pipe_advance),
		.ex_valid     (exi.ex_valid),
		.ex_rd        (exi.ex_rd),
		.wb_valid     (wb_valid),
		.wb_rd        (wb_rd),
		.wb_data      (wb_data),
		.rf_wr_idx    (wb_rd),
		.rf_wr_en     (rf_wr_en),
		.opi          (opi.issue)
	);

	// Processing
	operand_mux u_operand_mux (
		.clk          (clk),
		.rst_n        (rst_n),
		.pipe_advance (pipe_advance),
		.ex_forw      (alu_result),
		.wb_forw      (wb_data),
		.opi          (opi.operand),
		.exi          (exi.operand)
	);

	exec_alu u_exec_alu (
		.exi        (exi.alu),
		.alu_result (alu_result)
	);

	// Output side
	writeback_stage u_writeback_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.ex_valid     (exi.ex_valid),
		.ex_rd        (exi.ex_rd),
		.alu_result   (alu_result),
		.res_valid    (res_valid),
		.res_ready    (res_ready),
		.res_rd       (res_rd),
		.res_data     (res_data),
		.wb_valid     (wb_valid),
		.wb_rd        (wb_rd),
		.wb_data      (wb_data),
		.rf_wr_en     (rf_wr_en),
		.pipe_advance (pipe_advance)
	);

endmodule

// File: verif/exec_tb.sv
/*
 * Directed testbench for the execute pipeline.
 * Streams instruction words into exec_core_top and predicts every
 * result with a reference register model. Covers the ALU operations,
 * both forwarding paths, output back-pressure and r0.
 */

`timescale 1ns/10ps

module exec_tb;

	localparam int WAIT_LIMIT = 200;

	logic                clk;
	logic                rst_n;
	logic                instr_valid;
	logic                instr_ready;
	exec_pkg::word_t     instr_word;
	logic                res_valid;
	logic                res_ready;
	exec_pkg::reg_idx_t  res_rd;
	exec_pkg::word_t     res_data;

	// Reference register file with r0 never written
	exec_pkg::word_t     ref_regs [16];

	// Words to send and results to expect in the current stream
	exec_pkg::word_t     stim_q [$];
	exec_pkg::reg_idx_t  exp_rd_q [$];
	exec_pkg::word_t     exp_data_q [$];

	int err_count;
	int check_count;
	int test_count;
	bit abort;

	exec_core_top u_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.instr_word  (instr_word),
		.res_valid   (res_valid),
		.res_ready   (res_ready),
		.res_rd      (res_rd),
		.res_data    (res_data)
	);

	// 4 ns clock
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////
	// Compare tasks
	////////////////////

	task automatic compare_word(input string name, input exec_pkg::word_t got,
		input exec_pkg::word_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_idx(input string name, input exec_pkg::reg_idx_t got,
		input exec_pkg::reg_idx_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		err_count++;
		abort = 1'b1;
		$display("Timeout at %0t: %s", $time, what);
	endtask

	task automatic end_test(input string name, input int err_before);
		test_count++;
		$display("%s finished at %0t with %0d errors", name, $time, err_count - err_before);
	endtask

	////////////////////
	// Instruction words and model
	////////////////////

	function automatic exec_pkg::word_t make_rr(input exec_pkg::alu_op_e op,
		input exec_pkg::reg_idx_t rd, input exec_pkg::reg_idx_t ra,
		input exec_pkg::reg_idx_t rb);
		exec_pkg::instr_u u;
		u = '0;
		u.rr.op = op;
		u.rr.is_imm = 1'b0;
		u.rr.rd = rd;
		u.rr.ra = ra;
		u.rr.rb = rb;
		return u;
	endfunction

	function automatic exec_pkg::word_t make_ri(input exec_pkg::alu_op_e op,
		input exec_pkg::reg_idx_t rd, input exec_pkg::reg_idx_t ra, input logic [15:0] simm);
		exec_pkg::instr_u u;
		u = '0;
		u.ri.op = op;
		u.ri.is_imm = 1'b1;
		u.ri.rd = rd;
		u.ri.ra = ra;
		u.ri.simm = simm;
		return u;
	endfunction

	// Predict in program order, then queue word and expected result
	task automatic add_instr(input exec_pkg::word_t w);
		exec_pkg::instr_u u;
		exec_pkg::word_t  a;
		exec_pkg::word_t  b;
		exec_pkg::word_t  r;
		u = w;
		a = ref_regs[u.rr.ra];
		if (u.ri.is_imm) begin
			b = {{16{u.ri.simm[15]}}, u.ri.simm};
		end else begin
			b = ref_regs[u.rr.rb];
		end
		case (u.rr.op)
			exec_pkg::ALU_ADD: r = a + b;
			exec_pkg::ALU_SUB: r = a - b;
			exec_pkg::ALU_AND: r = a & b;
			exec_pkg::ALU_OR:  r = a | b;
			exec_pkg::ALU_XOR: r = a ^ b;
			exec_pkg::ALU_SLL: r = a << b[4:0];
			exec_pkg::ALU_SRL: r = a >> b[4:0];
			exec_pkg::ALU_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default:           r = '0;
		endcase
		// r0 result still goes out, but is not kept
		if (u.rr.rd != 0) begin
			ref_regs[u.rr.rd] = r;
		end
		stim_q.push_back(w);
		exp_rd_q.push_back(u.rr.rd);
		exp_data_q.push_back(r);
	endtask

	////////////////////
	// Drive and collect
	////////////////////

	// Entered one step after a rising edge, returns the same way
	task automatic send_instr(input exec_pkg::word_t w);
		int waited;
		bit taken;
		waited = 0;
		taken = 1'b0;
		instr_valid = 1'b1;
		instr_word = w;
		while (!taken && !abort) begin
			@(negedge clk);
			if (instr_ready) begin
				taken = 1'b1;
			end else if (waited == WAIT_LIMIT) begin
				report_timeout("instr_ready stayed low for an offered instruction");
			end
			waited++;
			@(posedge clk);
			#1;
		end
		instr_valid = 1'b0;
	endtask

	task automatic collect_result(input exec_pkg::reg_idx_t exp_rd,
		input exec_pkg::word_t exp_data, input bit stall);
		int waited;
		bit done;
		bit held;
		exec_pkg::reg_idx_t held_rd;
		exec_pkg::word_t    held_data;
		waited = 0;
		done = 1'b0;
		held = 1'b0;
		held_rd = '0;
		held_data = '0;
		while (!done && !abort) begin
			// Ready low about one cycle in three under stall
			res_ready = stall ? (($urandom % 3) != 0) : 1'b1;
			@(negedge clk);
			if (res_valid) begin
				// Offered result may not change while it waits
				if (held) begin
					compare_idx("res_rd while held", res_rd, held_rd);
					compare_word("res_data while held", res_data, held_data);
				end
				if (res_ready) begin
					compare_idx("res_rd", res_rd, exp_rd);
					compare_word("res_data", res_data, exp_data);
					done = 1'b1;
				end else begin
					held = 1'b1;
					held_rd = res_rd;
					held_data = res_data;
				end
			end else if (held) begin
				err_count++;
				held = 1'b0;
				$display("At %0t res_valid dropped before its result was taken", $time);
			end
			if (!done && waited == WAIT_LIMIT) begin
				report_timeout("no result was offered on the output");
			end
			waited++;
			@(posedge clk);
			#1;
		end
		res_ready = 1'b0;
	endtask

	// Send and collect side by side, then check nothing extra is offered
	task automatic run_stream(input bit stall);
		fork
			begin
				for (int i = 0; i < stim_q.size(); i++) begin
					send_instr(stim_q[i]);
				end
			end
			begin
				for (int j = 0; j < exp_rd_q.size(); j++) begin
					collect_result(exp_rd_q[j], exp_data_q[j], stall);
				end
			end
		join
		if (!abort) begin
			@(negedge clk);
			compare_bit("res_valid after stream", res_valid, 1'b0);
			@(posedge clk);
			#1;
		end
		stim_q.delete();
		exp_rd_q.delete();
		exp_data_q.delete();
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic check_reset_state();
		int e0;
		e0 = err_count;
		@(negedge clk);
		compare_bit("res_valid", res_valid, 1'b0);
		compare_bit("instr_ready", instr_ready, 1'b1);
		@(posedge clk);
		#1;
		end_test("reset_state", e0);
	endtask

	task automatic run_alu_ops();
		int e0;
		exec_pkg::alu_op_e op;
		e0 = err_count;
		// Seed registers through add-immediate from r0
		add_instr(make_ri(exec_pkg::ALU_ADD, 1, 0, 16'd100));
		add_instr(make_ri(exec_pkg::ALU_ADD, 2, 0, 16'hfff9));
		add_instr(make_ri(exec_pkg::ALU_ADD, 3, 0, 16'h7fff));
		add_instr(make_ri(exec_pkg::ALU_ADD, 4, 0, 16'h8000));
		add_instr(make_ri(exec_pkg::ALU_ADD, 5, 0, 16'd5));
		add_instr(make_ri(exec_pkg::ALU_ADD, 7, 0, 16'hffff));
		for (int k = 0; k < 8; k++) begin
			op = exec_pkg::alu_op_e'(k);
			add_instr(make_rr(op, 9, 1, 2));
			add_instr(make_rr(op, 10, 2, 1));
			add_instr(make_rr(op, 11, 4, 3));
			add_instr(make_ri(op, 12, 2, 16'hfffd));
			add_instr(make_ri(op, 13, 7, 16'd5));
		end
		run_stream(1'b0);
		end_test("alu_ops", e0);
	endtask

	// Every word reads the one just before it
	task automatic chain_ex_forward();
		int e0;
		exec_pkg::alu_op_e op;
		e0 = err_count;
		add_instr(make_ri(exec_pkg::ALU_ADD, 9, 0, 16'd3));
		for (int k = 0; k < 8; k++) begin
			op = exec_pkg::alu_op_e'(k);
			add_instr(make_rr(op, 9, 9, 5));
			add_instr(make_ri(exec_pkg::ALU_ADD, 9, 9, 16'h0123));
			add_instr(make_rr(op, 9, 1, 9));
			add_instr(make_rr(op, 9, 9, 9));
		end
		run_stream(1'b0);
		end_test("ex_forward", e0);
	endtask

	// One filler gives writeback forwarding, two give a register file read
	task automatic space_dependents();
		int e0;
		logic [15:0] imm;
		e0 = err_count;
		for (int gap = 1; gap <= 2; gap++) begin
			for (int k = 0; k < 3; k++) begin
				imm = k * 1000 + gap * 17 + 5;
				// Dependent read on operand A
				add_instr(make_ri(exec_pkg::ALU_ADD, 10, 0, imm));
				for (int f = 0; f < gap; f++) begin
					add_instr(make_ri(exec_pkg::ALU_XOR, 14, 3, imm));
				end
				add_instr(make_rr(exec_pkg::ALU_SUB, 11, 10, 5));
				// Dependent read on operand B
				add_instr(make_ri(exec_pkg::ALU_ADD, 10, 0, imm + 16'd9));
				for (int f = 0; f < gap; f++) begin
					add_instr(make_ri(exec_pkg::ALU_XOR, 14, 3, imm));
				end
				add_instr(make_rr(exec_pkg::ALU_SUB, 12, 5, 10));
			end
		end
		run_stream(1'b0);
		end_test("wb_rf_forward", e0);
	endtask

	// Few registers so most words depend on recent ones
	task automatic stall_results();
		int e0;
		exec_pkg::alu_op_e  op;
		exec_pkg::reg_idx_t rd;
		exec_pkg::reg_idx_t ra;
		exec_pkg::reg_idx_t rb;
		logic [15:0]        imm;
		e0 = err_count;
		for (int n = 0; n < 40; n++) begin
			op = exec_pkg::alu_op_e'($urandom % 8);
			rd = 1 + ($urandom % 4);
			ra = 1 + ($urandom % 4);
			rb = 1 + ($urandom % 4);
			imm = $urandom;
			if (($urandom % 2) != 0) begin
				add_instr(make_ri(op, rd, ra, imm));
			end else begin
				add_instr(make_rr(op, rd, ra, rb));
			end
		end
		run_stream(1'b1);
		end_test("backpressure", e0);
	endtask

	task automatic write_and_read_r0();
		int e0;
		e0 = err_count;
		add_instr(make_ri(exec_pkg::ALU_ADD, 0, 0, 16'd77));
		add_instr(make_rr(exec_pkg::ALU_ADD, 5, 0, 0));
		add_instr(make_ri(exec_pkg::ALU_OR, 0, 1, 16'hffff));
		add_instr(make_rr(exec_pkg::ALU_OR, 6, 0, 1));
		add_instr(make_rr(exec_pkg::ALU_SUB, 7, 1, 0));
		add_instr(make_ri(exec_pkg::ALU_ADD, 8, 0, 16'd0));
		run_stream(1'b0);
		end_test("r0_zero", e0);
	endtask

	initial begin
		void'($urandom(32'hdd24_e1cd));
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr_word = '0;
		res_ready = 1'b0;
		err_count = 0;
		check_count = 0;
		test_count = 0;
		abort = 1'b0;
		for (int i = 0; i < 16; i++) begin
			ref_regs[i] = '0;
		end
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_reset_state();
		run_alu_ops();
		chain_ex_forward();
		space_dependents();
		stall_results();
		write_and_read_r0();
		$display("tests run %0d, checks %0d, errors %0d", test_count, check_count, err_count);
		if (err_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: tb.f
+incdir+hw
hw/exec_pkg.sv
hw/operand_if.sv
hw/exec_if.sv
hw/reg_file.sv
hw/issue_decode.sv
hw/operand_mux.sv
hw/exec_alu.sv
hw/writeback_stage.sv
hw/exec_core_top.sv
verif/exec_tb.sv

// File: Bender.yml
package:
  name: exec_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/exec_pkg.sv
      - hw/operand_if.sv
      - hw/exec_if.sv
      - hw/reg_file.sv
      - hw/issue_decode.sv
      - hw/operand_mux.sv
      - hw/exec_alu.sv
      - hw/writeback_stage.sv
      - hw/exec_core_top.sv
  - target: test
    files:
      - verif/exec_tb.sv
